// ==== src.f ====
+incdir+rtl
rtl/ucodePkg.sv
rtl/flowDispatch.sv
rtl/ucodeRom.sv
rtl/ucodeSequencer.sv
rtl/ucodeTop.sv
testbench/ucodeTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the microcode front end testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f src.f --top-module ucodeTb -o ucodeSim &&
./obj_dir/ucodeSim > sim.log 2>&1 &&
grep -F -q "*** TEST PASSED ***" sim.log ||
{ cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }

cat sim.log
echo "Simulation passed"

// ==== testbench/ucodeTb.sv ====
`timescale 1ns/1ps
`include "ucode_macros.svh"

module ucodeTb;

	import ucodePkg::*;

	localparam int instrCount = 40;
	localparam int cycleLimit = instrCount * 12;

	logic clock;
	logic rstN;
	logic opcodeValid;
	opcode_t opcode;
	opcode_t cbOpcode;
	logic zeroFlag;
	logic uopValid;
	uop_t uop;
	logic busy;

	int errorCount;
	int checkCount;
	int cycleCount;
	int instrDone;

	// Row order NOP, LDrn_b, INCr_c, JRNZn z set, JRNZn z clear, CPn, PUSHBC,
	// MAPcb BIT7, MAPcb other, unlisted
	int flowLen [10] = '{1, 3, 1, 3, 6, 4, 6, 4, 4, 2};
	int flowPcCount [10] = '{1, 2, 1, 2, 2, 2, 1, 2, 2, 1};

	// First clean run of each row
	uop_t refWords [10][8];
	int refLen [10];

	ucodeTop u_ucodeTop
	(
		.clock(clock),
		.rstN(rstN),
		.opcodeValid(opcodeValid),
		.opcode(opcode),
		.cbOpcode(cbOpcode),
		.zeroFlag(zeroFlag),
		.uopValid(uopValid),
		.uop(uop),
		.busy(busy)
	);

	always
	begin
		#20 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles (%0d errors so far)",
				cycleLimit, errorCount);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic checkValue(input string sigName, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		assert (got === expected)
		else
		begin
			errorCount++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
				sigName, got, expected, $time);
		end
	endtask

	// True when the word ends the flow for the given zero flag
	function automatic logic endsFlow(input pcAction_t action, input logic zf);
		case (action)
			eof, incEof, incEofFu, eofFu:
				return 1'b1;
			incEofZ:
				return zf;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic advancesPc(input pcAction_t action);
		case (action)
			inc, incEof, incEofFu, incEofZ:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic isKept(input opcode_t code);
		case (code)
			`OP_NOP, `OP_LDRN_B, `OP_INCR_C, `OP_JRNZN, `OP_PUSHBC, `OP_MAPCB, `OP_CPN:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic opcode_t rowOpcode(input int row);
		case (row)
			1: return `OP_LDRN_B;
			2: return `OP_INCR_C;
			3, 4: return `OP_JRNZN;
			5: return `OP_CPN;
			6: return `OP_PUSHBC;
			7, 8: return `OP_MAPCB;
			default: return `OP_NOP;
		endcase
	endfunction

	////////////////////
	// One instruction
	////////////////////

	task automatic runInstruction(input int row, input logic interfere);
		opcode_t opByte;
		opcode_t cbByte;
		logic zf;
		int gap;
		int count;
		int pcCount;
		int strobeAt;
		int i;
		uop_t words [8];

		opByte = rowOpcode(row);
		cbByte = opcode_t'($urandom);
		zf = ($urandom % 2) != 0;
		case (row)
			3: zf = 1'b1;
			4: zf = 1'b0;
			7: cbByte = `OP_CB_BIT7;
			8:
			begin
				while (cbByte == `OP_CB_BIT7)
					cbByte = opcode_t'($urandom);
			end
			9:
			begin
				opByte = opcode_t'($urandom);
				while (isKept(opByte))
					opByte = opcode_t'($urandom);
			end
			default:
			begin
			end
		endcase

		gap = $urandom % 3;
		repeat (gap)
		begin
			checkValue("uopValid", uopValid, 0);
			@(negedge clock);
		end

		// Strobe from idle only
		checkValue("busy", busy, 0);
		checkValue("uopValid", uopValid, 0);
		opcodeValid = 1'b1;
		opcode = opByte;
		cbOpcode = cbByte;
		zeroFlag = zf;
		strobeAt = interfere ? 1 + ($urandom % flowLen[row]) : 0;
		@(negedge clock);
		opcodeValid = 1'b0;

		// First word one cycle after the accepting edge
		checkValue("uopValid", uopValid, 1);
		count = 0;
		pcCount = 0;
		while (uopValid === 1'b1 && count < 8)
		begin
			checkValue("busy", busy, 1);
			words[count] = uop;
			if (count > 0)
				checkValue("uop.pcAction ends flow early",
					endsFlow(words[count - 1].pcAction, zf), 0);
			if (advancesPc(uop.pcAction))
				pcCount++;
			count++;
			// Stray strobe while the flow runs
			if (count == strobeAt)
			begin
				opcodeValid = 1'b1;
				opcode = opcode_t'($urandom);
			end
			@(negedge clock);
			opcodeValid = 1'b0;
		end

		checkValue("busy", busy, 0);
		checkValue("flow length", count, flowLen[row]);
		checkValue("pc-advancing words", pcCount, flowPcCount[row]);
		if (count > 0)
		begin
			checkValue("last uop.pcAction ends flow",
				endsFlow(words[count - 1].pcAction, zf), 1);
			case (row)
				3: checkValue("last uop.pcAction", words[count - 1].pcAction, incEofZ);
				7:
				begin
					checkValue("last uop.operation", words[count - 1].operation, bitTest);
					checkValue("last uop.pcAction", words[count - 1].pcAction, eofFu);
				end
				8: checkValue("last uop.operation", words[count - 1].operation, nop);
				9: checkValue("first uop.operation", words[0].operation, z801bop);
				default:
				begin
				end
			endcase
		end

		// Same row must repeat word for word
		if (refLen[row] == 0)
		begin
			refLen[row] = count;
			for (i = 0; i < count; i++)
				refWords[row][i] = words[i];
		end
		else
		begin
			checkValue("flow length vs first run", count, refLen[row]);
			for (i = 0; i < count && i < refLen[row]; i++)
				checkValue($sformatf("uop[%0d]", i), words[i], refWords[row][i]);
		end
		instrDone++;
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		int row;
		logic interfere;

		void'($urandom(32'h1d0a7ec9));
		clock = 1'b0;
		rstN = 1'b0;
		opcodeValid = 1'b0;
		opcode = '0;
		cbOpcode = '0;
		zeroFlag = 1'b0;

		// Strobe during reset must be lost
		for (row = 0; row < 8; row++)
		begin
			@(negedge clock);
			checkValue("uopValid", uopValid, 0);
			checkValue("busy", busy, 0);
			opcodeValid = (row >= 2 && row < 5);
			opcode = `OP_PUSHBC;
		end
		opcodeValid = 1'b0;
		rstN = 1'b1;
		@(negedge clock);
		checkValue("uopValid", uopValid, 0);
		checkValue("busy", busy, 0);

		// Every row once without stray strobes
		for (row = 0; row < 10; row++)
			runInstruction(row, 1'b0);

		repeat (instrCount - 10)
		begin
			row = $urandom % 10;
			interfere = ($urandom % 2) != 0;
			runInstruction(row, interfere);
		end

		$display("Summary: %0d instructions, %0d checks, %0d errors",
			instrDone, checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== rtl/ucodeTop.sv ====
`timescale 1ns/1ps

module ucodeTop
(
	input logic clock,
	input logic rstN,
	input logic opcodeValid,
	input ucodePkg::opcode_t opcode,
	input ucodePkg::opcode_t cbOpcode,
	input logic zeroFlag,
	output logic uopValid,
	output ucodePkg::uop_t uop,
	output logic busy
);

	import ucodePkg::*;

	opcode_t dispatchOpcode;
	uAddr_t flowStart;
	uAddr_t uAddr;
	logic cbPage;

	////////////////////
	// Opcode to flow start
	////////////////////

	flowDispatch u_flowDispatch
	(
		.opcode(dispatchOpcode),
		.cbOpcode(cbOpcode),
		.cbPage(cbPage),
		.flowStart(flowStart)
	);

	// ROM word is the micro-op port itself
	ucodeRom u_ucodeRom
	(
		.uAddr(uAddr),
		.uop(uop)
	);

	ucodeSequencer u_ucodeSequencer
	(
		.clock(clock),
		.rstN(rstN),
		.opcodeValid(opcodeValid),
		.opcode(opcode),
		.zeroFlag(zeroFlag),
		.romUop(uop),
		.flowStart(flowStart),
		.dispatchOpcode(dispatchOpcode),
		.uAddr(uAddr),
		.cbPage(cbPage),
		.busy(busy),
		.uopValid(uopValid)
	);

endmodule

// ==== rtl/ucodeSequencer.sv ====
`timescale 1ns/1ps

module ucodeSequencer
(
	input logic clock,
	input logic rstN,
	input logic opcodeValid,
	input ucodePkg::opcode_t opcode,
	input logic zeroFlag,
	input ucodePkg::uop_t romUop,
	input ucodePkg::uAddr_t flowStart,
	output ucodePkg::opcode_t dispatchOpcode,
	output ucodePkg::uAddr_t uAddr,
	output logic cbPage,
	output logic busy,
	output logic uopValid
);

	import ucodePkg::*;

	seqState_t state;
	logic running;
	logic endFlow;
	logic accept;

	////////////////////
	// Decode of the current word
	////////////////////

	assign running = (state == run);

	// Opcode goes straight to the base table
	assign dispatchOpcode = opcode;

	// Strobes while a flow runs are dropped
	assign accept = !running && opcodeValid;

	always_comb
	begin
		case (romUop.pcAction)
			eof, incEof, incEofFu, eofFu:
				endFlow = 1'b1;
			// Conditional return on zero
			incEofZ:
				endFlow = zeroFlag;
			default:
				endFlow = 1'b0;
		endcase
	end

	// CB table lookup replaces the increment
	assign cbPage = running && (romUop.operation == jcb);

	////////////////////
	// FSM and micro-address
	////////////////////

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			uAddr <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (accept)
					begin
						uAddr <= flowStart;
						state <= run;
					end
				end
				run:
				begin
					if (cbPage)
					begin
						uAddr <= flowStart;
					end
					else if (endFlow)
					begin
						state <= idle;
					end
					else
					begin
						uAddr <= uAddr + 1'b1;
					end
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	// One micro-op per cycle while running
	assign busy = running;
	assign uopValid = running;

endmodule

// ==== rtl/ucodeRom.sv ====
`timescale 1ns/1ps
`include "ucode_macros.svh"

module ucodeRom
(
	input ucodePkg::uAddr_t uAddr,
	output ucodePkg::uop_t uop
);

	import ucodePkg::*;

	always_comb
	begin
		case (uAddr)

			////////////////////
			// Shared flows
			////////////////////

			// Unlisted opcode, generic one byte op on a
			`FLOW_DEFAULT:
				uop = '{updateFlags, z801bop, a};
			`FLOW_DEFAULT + 6'd1:
				uop = '{incEof, nop, none};

			// CB byte without its own flow
			`FLOW_CB_NOP:
				uop = '{eof, nop, none};

			// BIT7, flags only
			`FLOW_CB_BIT7:
				uop = '{eofFu, bitTest, none};

			////////////////////
			// Base page flows
			////////////////////

			`FLOW_NOP:
				uop = '{incEof, nop, none};

			// LDrn_b, immediate byte into b
			`FLOW_LDRN_B:
				uop = '{inc, sma, pc};
			`FLOW_LDRN_B + 6'd1:
				uop = '{inc, nop, none};
			`FLOW_LDRN_B + 6'd2:
				uop = '{eof, srm, b};

			// INCr_c
			`FLOW_INCR_C:
				uop = '{incEofFu, inc16, c};

			// JRNZn
			`FLOW_JRNZN:
				uop = '{inc, sma, pc};
			`FLOW_JRNZN + 6'd1:
				uop = '{op, nop, none};
			// Leaves here when z is set, else fetches the offset
			`FLOW_JRNZN + 6'd2:
				uop = '{incEofZ, srm, x8};
			`FLOW_JRNZN + 6'd3:
				uop = '{op, sx16r, pc};
			// x16 = pc + signed offset
			`FLOW_JRNZN + 6'd4:
				uop = '{op, addx16, x8};
			`FLOW_JRNZN + 6'd5:
				uop = '{eof, spc, x16};

			// CPn, a minus immediate for flags only
			`FLOW_CPN:
				uop = '{inc, sx16r, a};
			`FLOW_CPN + 6'd1:
				uop = '{op, nop, none};
			`FLOW_CPN + 6'd2:
				uop = '{op, srm, x8};
			`FLOW_CPN + 6'd3:
				uop = '{incEofFu, subx16, x8};

			// PUSHBC
			`FLOW_PUSHBC:
				uop = '{op, dec16, sp};
			`FLOW_PUSHBC + 6'd1:
				uop = '{op, sma, sp};
			`FLOW_PUSHBC + 6'd2:
				uop = '{op, smw, b};
			`FLOW_PUSHBC + 6'd3:
				uop = '{op, dec16, sp};
			`FLOW_PUSHBC + 6'd4:
				uop = '{op, smw, c};
			// Point memory back at pc
			`FLOW_PUSHBC + 6'd5:
				uop = '{incEof, sma, pc};

			// MAPcb, fetch the second byte then jump to the CB page
			`FLOW_MAPCB:
				uop = '{inc, sma, pc};
			`FLOW_MAPCB + 6'd1:
				uop = '{op, nop, none};
			`FLOW_MAPCB + 6'd2:
				uop = '{inc, jcb, none};

			default:
				uop = '{op, nop, none};
		endcase
	end

endmodule

// ==== rtl/flowDispatch.sv ====
`timescale 1ns/1ps
`include "ucode_macros.svh"

module flowDispatch
(
	input ucodePkg::opcode_t opcode,
	input ucodePkg::opcode_t cbOpcode,
	input logic cbPage,
	output ucodePkg::uAddr_t flowStart
);

	import ucodePkg::*;

	uAddr_t baseStart;
	uAddr_t cbStart;

	////////////////////
	// Base page
	////////////////////

	always_comb
	begin
		case (opcode)
			`OP_NOP:
				baseStart = `FLOW_NOP;
			`OP_LDRN_B:
				baseStart = `FLOW_LDRN_B;
			`OP_INCR_C:
				baseStart = `FLOW_INCR_C;
			`OP_JRNZN:
				baseStart = `FLOW_JRNZN;
			`OP_PUSHBC:
				baseStart = `FLOW_PUSHBC;
			`OP_MAPCB:
				baseStart = `FLOW_MAPCB;
			`OP_CPN:
				baseStart = `FLOW_CPN;
			// Anything else runs as a generic one byte op
			default:
				baseStart = `FLOW_DEFAULT;
		endcase
	end

	////////////////////
	// CB page
	////////////////////

	always_comb
	begin
		case (cbOpcode)
			`OP_CB_BIT7:
				cbStart = `FLOW_CB_BIT7;
			default:
				cbStart = `FLOW_CB_NOP;
		endcase
	end

	// Sequencer picks the page on a jcb word
	assign flowStart = cbPage ? cbStart : baseStart;

endmodule

// ==== rtl/ucodePkg.sv ====
`include "ucode_macros.svh"

package ucodePkg;

	////////////////////
	// Plain vectors
	////////////////////

	// Opcode byte or CB page byte
	typedef logic [`UCODE_OPCODE_W-1:0] opcode_t;

	// Microcode ROM address
	typedef logic [`UCODE_ADDR_W-1:0] uAddr_t;

	////////////////////
	// Micro-op fields
	////////////////////

	// What happens to pc and to the flow after this word
	typedef enum logic [3:0]
	{
		op = 4'd0,
		inc = 4'd1,
		eof = 4'd2,
		incEof = 4'd3,
		incEofFu = 4'd4,
		eofFu = 4'd5,
		incEofZ = 4'd6,
		updateFlags = 4'd7
	} pcAction_t;

	// Datapath operation, executed outside this block
	typedef enum logic [3:0]
	{
		nop = 4'd0,
		sma = 4'd1,
		smw = 4'd2,
		srm = 4'd3,
		sx16r = 4'd4,
		spc = 4'd5,
		addx16 = 4'd6,
		subx16 = 4'd7,
		inc16 = 4'd8,
		dec16 = 4'd9,
		jcb = 4'd10,
		bitTest = 4'd11,
		z801bop = 4'd12
	} uOperation_t;

	typedef enum logic [3:0]
	{
		none = 4'd0,
		pc = 4'd1,
		pch = 4'd2,
		sp = 4'd3,
		a = 4'd4,
		b = 4'd5,
		c = 4'd6,
		x8 = 4'd7,
		x16 = 4'd8
	} uOperand_t;

	// One ROM word, 12 bits
	typedef struct packed
	{
		pcAction_t pcAction;
		uOperation_t operation;
		uOperand_t operand;
	} uop_t;

	// Sequencer FSM
	typedef enum logic
	{
		idle = 1'b0,
		run = 1'b1
	} seqState_t;

endpackage

// ==== rtl/ucode_macros.svh ====
`ifndef UCODE_MACROS_SVH
`define UCODE_MACROS_SVH

////////////////////
// Widths
////////////////////

`define UCODE_OPCODE_W 8
`define UCODE_ADDR_W 6

////////////////////
// Flow start addresses
////////////////////

// Shared default for every opcode without its own flow
`define FLOW_DEFAULT 6'd0
// CB page entries
`define FLOW_CB_NOP 6'd2
`define FLOW_CB_BIT7 6'd3
// Base page entries
`define FLOW_NOP 6'd4
`define FLOW_LDRN_B 6'd5
`define FLOW_INCR_C 6'd8
`define FLOW_JRNZN 6'd9
`define FLOW_CPN 6'd15
`define FLOW_PUSHBC 6'd19
`define FLOW_MAPCB 6'd25

////////////////////
// Opcode values
////////////////////

`define OP_NOP 8'h00
`define OP_LDRN_B 8'h06
`define OP_INCR_C 8'h0C
`define OP_JRNZN 8'h20
`define OP_PUSHBC 8'hC5
`define OP_MAPCB 8'hCB
`define OP_CPN 8'hFE

// Second byte after the CB prefix
`define OP_CB_BIT7 8'h7C

`endif
